/* logic/core_pkg.sv */
// Core sizing package
// Pipeline sizes and the vector types for sequence numbers,
// register values and register indices

`default_nettype none

package core_pkg;

  // Sequence number space
  localparam int SEQ_BITS      = 3;
  localparam int NUM_SEQ       = 2 ** SEQ_BITS;
  // Freed tail entries reclaimed per cycle
  localparam int RECLAIM_WIDTH = 2;

  // Register file
  localparam int DATA_BITS     = 16;
  localparam int NUM_REGS      = 4;
  localparam int REG_ADDR_BITS = $clog2(NUM_REGS);

  typedef logic [SEQ_BITS-1:0]      seq_num_t;
  typedef logic [DATA_BITS-1:0]     data_t;
  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;

endpackage

`default_nettype wire

/* logic/isa_pkg.sv */
// Instruction set package
// Field positions of the 16-bit instruction word and the opcode encoding

`default_nettype none

package isa_pkg;

  localparam int INSTR_BITS = 16;
  localparam int IMM_BITS   = 10;

  // Field boundaries inside the instruction word
  localparam int OP_MSB  = 15;
  localparam int OP_LSB  = 14;
  localparam int RD_MSB  = 13;
  localparam int RD_LSB  = 12;
  localparam int RS_MSB  = 11;
  localparam int RS_LSB  = 10;
  localparam int IMM_MSB = 9;
  localparam int IMM_LSB = 0;

  typedef logic [INSTR_BITS-1:0] instr_t;
  typedef logic [IMM_BITS-1:0]   imm_t;

  typedef enum logic [1:0] {
    OP_NOP  = 2'd0,
    OP_ADDI = 2'd1,
    OP_XORI = 2'd2,
    OP_BEQZ = 2'd3
  } opcode_e;

endpackage

`default_nettype wire

/* logic/core_if.sv */
// Pipeline stage interfaces
// Decoded uop, executed result and commit notification bundles

`default_nettype none

// Decode to execute
interface uop_if;
  logic                 val;
  core_pkg::seq_num_t   seq_num;
  isa_pkg::opcode_e     op;
  core_pkg::reg_addr_t  rd;
  core_pkg::reg_addr_t  rs;
  isa_pkg::imm_t        imm;

  modport source (output val, seq_num, op, rd, rs, imm);
  modport sink   (input  val, seq_num, op, rd, rs, imm);
endinterface

// Execute to result
interface exec_if;
  logic                 val;
  core_pkg::seq_num_t   seq_num;
  isa_pkg::opcode_e     op;
  core_pkg::reg_addr_t  rd;
  core_pkg::data_t      value;
  logic                 wen;
  logic                 taken;

  modport source (output val, seq_num, op, rd, value, wen, taken);
  modport sink   (input  val, seq_num, op, rd, value, wen, taken);
endinterface

// Result to execute and the generator, one pulse per retired instruction
interface commit_if;
  logic                 val;
  core_pkg::seq_num_t   seq_num;
  logic                 wen;
  core_pkg::reg_addr_t  waddr;
  core_pkg::data_t      wdata;

  modport source (output val, seq_num, wen, waddr, wdata);
  modport sink   (input  val, seq_num, wen, waddr, wdata);
endinterface

`default_nettype wire

/* logic/seq_num_gen.sv */
// Sequence number generator
// Hands out numbers at the head, frees them on commit or squash,
// and reclaims freed entries in order at the tail

`default_nettype none

module seq_num_gen (
  input  logic               clk,
  input  logic               rst,

  // Allocation port
  output logic               alloc_val,
  output core_pkg::seq_num_t alloc_seq_num,
  input  logic               alloc_rdy,

  // Frees
  commit_if.sink             commit,

  // Squash strobe
  input  logic               squash_val,
  input  core_pkg::seq_num_t squash_seq_num
);

  // One bit per number, set while the number is in use
  logic [core_pkg::NUM_SEQ-1:0] alloc_list;

  core_pkg::seq_num_t head;
  core_pkg::seq_num_t head_next;
  core_pkg::seq_num_t tail;
  core_pkg::seq_num_t tail_incr;
  core_pkg::seq_num_t in_use;
  core_pkg::seq_num_t squash_age;
  logic               alloc_fire;

  //--------------------------------------------------------------------
  // Allocation
  //--------------------------------------------------------------------

  // Head may never catch up with the tail
  assign alloc_val  = !(core_pkg::seq_num_t'(head + 1'b1) == tail);
  assign alloc_fire = alloc_val & alloc_rdy;

  // Squash rewinds the head right behind the branch
  assign alloc_seq_num = squash_val ? core_pkg::seq_num_t'(squash_seq_num + 1'b1)
                                    : head;

  always_comb begin
    head_next = alloc_seq_num;
    if (alloc_fire) begin
      head_next = core_pkg::seq_num_t'(alloc_seq_num + 1'b1);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
    end else begin
      head <= head_next;
    end
  end

  //--------------------------------------------------------------------
  // Entry list
  //--------------------------------------------------------------------

  // Age of the branch, counted from the tail
  assign squash_age = core_pkg::seq_num_t'(squash_seq_num - tail);

  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_list <= '0;
    end else begin
      for (int i = 0; i < core_pkg::NUM_SEQ; i++) begin
        // Retired number
        if (commit.val && commit.seq_num == core_pkg::seq_num_t'(i)) begin
          alloc_list[i] <= 1'b0;
        end
        // Younger than the branch means further from the tail
        if (squash_val && core_pkg::seq_num_t'(i - tail) > squash_age) begin
          alloc_list[i] <= 1'b0;
        end
        // New owner wins over a stale clear
        if (alloc_fire && alloc_seq_num == core_pkg::seq_num_t'(i)) begin
          alloc_list[i] <= 1'b1;
        end
      end
    end
  end

  //--------------------------------------------------------------------
  // Reclaim at the tail
  //--------------------------------------------------------------------

  // Numbers between tail and head
  assign in_use = core_pkg::seq_num_t'(head - tail);

  // Walk forward over a contiguous run of freed entries
  always_comb begin
    logic run;
    tail_incr = '0;
    run       = 1'b1;
    for (int k = 0; k < core_pkg::RECLAIM_WIDTH; k++) begin
      if (run && !alloc_list[core_pkg::seq_num_t'(tail + k)] &&
          core_pkg::seq_num_t'(k) < in_use) begin
        tail_incr = core_pkg::seq_num_t'(tail_incr + 1'b1);
      end else begin
        run = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tail <= '0;
    end else begin
      tail <= core_pkg::seq_num_t'(tail + tail_incr);
    end
  end

endmodule

`default_nettype wire

/* logic/decode_unit.sv */
// Decode stage
// Accepts instructions with a fresh sequence number, buffers them
// for one cycle, then splits the fields into a uop register

`default_nettype none

module decode_unit (
  input  logic               clk,
  input  logic               rst,

  input  logic               instr_val,
  output logic               instr_rdy,
  input  isa_pkg::instr_t    instr,

  input  logic               alloc_val,
  output logic               alloc_rdy,
  input  core_pkg::seq_num_t alloc_seq_num,

  input  logic               squash_val,

  uop_if.source              uop
);

  logic               accept;
  logic               buf_val;
  isa_pkg::instr_t    buf_instr;
  core_pkg::seq_num_t buf_seq_num;

  // Stall on squash or when no number is free
  assign instr_rdy = alloc_val & ~squash_val;
  assign alloc_rdy = instr_val & ~squash_val;
  assign accept    = instr_val & instr_rdy;

  //--------------------------------------------------------------------
  // Input buffer
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      buf_val <= 1'b0;
    end else begin
      buf_val <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      buf_instr   <= instr;
      buf_seq_num <= alloc_seq_num;
    end
  end

  //--------------------------------------------------------------------
  // Field split
  //--------------------------------------------------------------------

  // Younger than a squashing branch, so dropped
  always_ff @(posedge clk) begin
    if (rst) begin
      uop.val <= 1'b0;
    end else begin
      uop.val <= buf_val & ~squash_val;
    end
  end

  always_ff @(posedge clk) begin
    uop.seq_num <= buf_seq_num;
    uop.op      <= isa_pkg::opcode_e'(buf_instr[isa_pkg::OP_MSB:isa_pkg::OP_LSB]);
    uop.rd      <= buf_instr[isa_pkg::RD_MSB:isa_pkg::RD_LSB];
    uop.rs      <= buf_instr[isa_pkg::RS_MSB:isa_pkg::RS_LSB];
    uop.imm     <= buf_instr[isa_pkg::IMM_MSB:isa_pkg::IMM_LSB];
  end

endmodule

`default_nettype wire

/* logic/execute_unit.sv */
// Execute stage
// Register file written from commit, operand read with write-through,
// ALU and zero-test branch evaluation into the result stage register

`default_nettype none

module execute_unit (
  input  logic   clk,
  input  logic   rst,
  uop_if.sink    uop,
  commit_if.sink commit,
  input  logic   squash_val,
  exec_if.source exe
);

  core_pkg::data_t regs [core_pkg::NUM_REGS];
  core_pkg::data_t rs_val;
  core_pkg::data_t imm_ext;
  core_pkg::data_t alu_out;
  logic            wr_en;
  logic            is_taken;

  //--------------------------------------------------------------------
  // Register file
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (commit.val && commit.wen) begin
      regs[commit.waddr] <= commit.wdata;
    end
  end

  // Same-cycle commit overrides the stored value
  assign rs_val = (commit.val && commit.wen && commit.waddr == uop.rs) ? commit.wdata
                                                                       : regs[uop.rs];

  //--------------------------------------------------------------------
  // ALU
  //--------------------------------------------------------------------

  assign imm_ext = {{(core_pkg::DATA_BITS - isa_pkg::IMM_BITS){uop.imm[isa_pkg::IMM_BITS-1]}},
                    uop.imm};

  always_comb begin
    alu_out  = '0;
    wr_en    = 1'b0;
    is_taken = 1'b0;
    case (uop.op)
      isa_pkg::OP_ADDI: begin
        alu_out = rs_val + imm_ext;
        wr_en   = 1'b1;
      end
      isa_pkg::OP_XORI: begin
        alu_out = rs_val ^ imm_ext;
        wr_en   = 1'b1;
      end
      // Branch on zero source
      isa_pkg::OP_BEQZ: is_taken = (rs_val == '0);
      default: ;
    endcase
  end

  //--------------------------------------------------------------------
  // Stage register
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      exe.val <= 1'b0;
    end else begin
      exe.val <= uop.val & ~squash_val;
    end
  end

  always_ff @(posedge clk) begin
    exe.seq_num <= uop.seq_num;
    exe.op      <= uop.op;
    exe.rd      <= uop.rd;
    exe.value   <= alu_out;
    exe.wen     <= wr_en;
    exe.taken   <= is_taken;
  end

endmodule

`default_nettype wire

/* logic/result_unit.sv */
// Result stage
// Retires the item in the execute stage register as a commit pulse
// and raises squash for a taken zero-test branch

`default_nettype none

module result_unit (
  exec_if.sink               exe,
  commit_if.source           commit,
  output logic               squash_val,
  output core_pkg::seq_num_t squash_seq_num
);

  //--------------------------------------------------------------------
  // Commit
  //--------------------------------------------------------------------

  // Every valid item retires, in order
  assign commit.val     = exe.val;
  assign commit.seq_num = exe.seq_num;

  // Writes only for ALU ops
  assign commit.wen     = exe.val & exe.wen;
  assign commit.waddr   = exe.rd;
  assign commit.wdata   = exe.value;

  //--------------------------------------------------------------------
  // Squash
  //--------------------------------------------------------------------

  // Branch carries its own number, younger ones get flushed
  assign squash_val     = exe.val & exe.taken & (exe.op == isa_pkg::OP_BEQZ);
  assign squash_seq_num = exe.seq_num;

endmodule

`default_nettype wire

/* logic/seq_core.sv */
// Sequence-numbered pipeline top level
// Decode, execute and result stages around the sequence number generator

`default_nettype none

module seq_core (
  input  logic                clk,
  input  logic                rst,

  // Instruction input
  input  logic                instr_val,
  output logic                instr_rdy,
  input  isa_pkg::instr_t     instr,

  // Commit strobe
  output logic                commit_val,
  output core_pkg::seq_num_t  commit_seq_num,
  output logic                commit_wen,
  output core_pkg::reg_addr_t commit_waddr,
  output core_pkg::data_t     commit_wdata,

  // Squash strobe
  output logic                squash_val,
  output core_pkg::seq_num_t  squash_seq_num
);

  uop_if    uop_bus ();
  exec_if   exe_bus ();
  commit_if commit_bus ();

  logic               alloc_val;
  logic               alloc_rdy;
  core_pkg::seq_num_t alloc_seq_num;

  //--------------------------------------------------------------------
  // Stages
  //--------------------------------------------------------------------

  seq_num_gen gen0 (
    .clk            (clk),
    .rst            (rst),
    .alloc_val      (alloc_val),
    .alloc_seq_num  (alloc_seq_num),
    .alloc_rdy      (alloc_rdy),
    .commit         (commit_bus.sink),
    .squash_val     (squash_val),
    .squash_seq_num (squash_seq_num)
  );

  decode_unit dec0 (
    .clk           (clk),
    .rst           (rst),
    .instr_val     (instr_val),
    .instr_rdy     (instr_rdy),
    .instr         (instr),
    .alloc_val     (alloc_val),
    .alloc_rdy     (alloc_rdy),
    .alloc_seq_num (alloc_seq_num),
    .squash_val    (squash_val),
    .uop           (uop_bus.source)
  );

  execute_unit exe0 (
    .clk        (clk),
    .rst        (rst),
    .uop        (uop_bus.sink),
    .commit     (commit_bus.sink),
    .squash_val (squash_val),
    .exe        (exe_bus.source)
  );

  result_unit res0 (
    .exe            (exe_bus.sink),
    .commit         (commit_bus.source),
    .squash_val     (squash_val),
    .squash_seq_num (squash_seq_num)
  );

  // Commit bundle out to the pins
  assign commit_val     = commit_bus.val;
  assign commit_seq_num = commit_bus.seq_num;
  assign commit_wen     = commit_bus.wen;
  assign commit_waddr   = commit_bus.waddr;
  assign commit_wdata   = commit_bus.wdata;

endmodule

`default_nettype wire

/* tb/tb_seq_core.sv */
// Testbench for the sequence-numbered pipeline
// Table-driven stimulus checked against an in-order reference model
// of sequence numbers, register values, commit latency and squash

`default_nettype none

module tb_seq_core;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  localparam int N_DIRECTED   = 16;
  localparam int N_TESTS      = 24;
  localparam int LATENCY      = 3;

  // Expected fate of a table entry
  localparam int FATE_COMMIT = 0;
  localparam int FATE_SQUASH = 1;
  localparam int FATE_DROP   = 2;
  localparam int FATE_ANY    = 3;

  logic                clk       = 1'b0;
  logic                rst       = 1'b1;
  logic                instr_val = 1'b0;
  isa_pkg::instr_t     instr     = '0;
  logic                instr_rdy;
  logic                commit_val;
  core_pkg::seq_num_t  commit_seq_num;
  logic                commit_wen;
  core_pkg::reg_addr_t commit_waddr;
  core_pkg::data_t     commit_wdata;
  logic                squash_val;
  core_pkg::seq_num_t  squash_seq_num;

  // Values for the next rising edge
  logic            drive_rst   = 1'b1;
  logic            drive_val   = 1'b0;
  isa_pkg::instr_t drive_instr = '0;

  // Stimulus table
  isa_pkg::instr_t prog     [N_TESTS];
  int              gap_cyc  [N_TESTS];
  int              fate_exp [N_TESTS];

  // Reference model state
  core_pkg::data_t    model_regs [core_pkg::NUM_REGS];
  core_pkg::seq_num_t exp_seq    [N_TESTS];
  int                 acc_cyc    [N_TESTS];
  int                 inflight   [$];
  core_pkg::seq_num_t next_seq;

  int cyc;
  int cur;
  int gap_left;
  int errors;
  int tests_run;
  int tests_failed;

  seq_core dut0 (
    .clk            (clk),
    .rst            (rst),
    .instr_val      (instr_val),
    .instr_rdy      (instr_rdy),
    .instr          (instr),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .commit_wen     (commit_wen),
    .commit_waddr   (commit_waddr),
    .commit_wdata   (commit_wdata),
    .squash_val     (squash_val),
    .squash_seq_num (squash_seq_num)
  );

  initial begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Inputs change only on the rising edge
  always @(posedge clk) begin
    rst       <= drive_rst;
    instr_val <= drive_val;
    instr     <= drive_instr;
  end

  //----------------------------------------------------------------------
  // Stimulus table
  //----------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic isa_pkg::instr_t make_instr(input isa_pkg::opcode_e op, input int rd,
                                                 input int rs, input int imm);
    return {op, 2'(rd), 2'(rs), 10'(imm)};
  endfunction

  task automatic set_entry(input int i, input isa_pkg::instr_t w, input int gap, input int fate);
    prog[i]     = w;
    gap_cyc[i]  = gap;
    fate_exp[i] = fate;
  endtask

  task automatic load_table();
    logic [31:0] rng;
    // Dependent chain where the second one needs the bypass
    set_entry(0,  make_instr(isa_pkg::OP_ADDI, 1, 0, 5),   0, FATE_COMMIT);
    set_entry(1,  make_instr(isa_pkg::OP_ADDI, 2, 1, 3),   0, FATE_COMMIT);
    set_entry(2,  make_instr(isa_pkg::OP_XORI, 3, 2, -1),  0, FATE_COMMIT);
    set_entry(3,  make_instr(isa_pkg::OP_ADDI, 1, 1, -7),  2, FATE_COMMIT);
    // No writes here
    set_entry(4,  make_instr(isa_pkg::OP_NOP,  3, 0, 77),  0, FATE_COMMIT);
    set_entry(5,  make_instr(isa_pkg::OP_BEQZ, 0, 2, 0),   0, FATE_COMMIT);
    // r0 still zero so taken and the next two are flushed
    set_entry(6,  make_instr(isa_pkg::OP_BEQZ, 0, 0, 0),   1, FATE_SQUASH);
    set_entry(7,  make_instr(isa_pkg::OP_ADDI, 1, 1, 100), 0, FATE_DROP);
    set_entry(8,  make_instr(isa_pkg::OP_XORI, 2, 2, 1),   0, FATE_DROP);
    set_entry(9,  make_instr(isa_pkg::OP_ADDI, 0, 2, 1),   0, FATE_COMMIT);
    set_entry(10, make_instr(isa_pkg::OP_BEQZ, 0, 0, 0),   0, FATE_COMMIT);
    set_entry(11, make_instr(isa_pkg::OP_XORI, 0, 0, 9),   0, FATE_COMMIT);
    // Branch source arrives through the bypass
    set_entry(12, make_instr(isa_pkg::OP_BEQZ, 0, 0, 0),   0, FATE_SQUASH);
    set_entry(13, make_instr(isa_pkg::OP_ADDI, 3, 3, 1),   0, FATE_DROP);
    set_entry(14, make_instr(isa_pkg::OP_ADDI, 3, 3, 2),   0, FATE_DROP);
    set_entry(15, make_instr(isa_pkg::OP_ADDI, 2, 3, 1),   3, FATE_COMMIT);
    // Random tail
    rng = 32'hed0e_bb97;
    for (int i = N_DIRECTED; i < N_TESTS; i++) begin
      rng = xorshift32(rng);
      set_entry(i, rng[15:0], (rng[19:18] == 2'd0) ? 1 : 0, FATE_ANY);
    end
  endtask

  //----------------------------------------------------------------------
  // Reporting
  //----------------------------------------------------------------------

  task automatic report_mismatch(input string what, input int got, input int exp);
    errors++;
    $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("At %0t: %s", $time, msg);
  endtask

  task automatic close_test(input int idx, input int fate, input int err_before);
    string outcome;
    case (fate)
      FATE_COMMIT: outcome = "committed";
      FATE_SQUASH: outcome = "committed with squash";
      default:     outcome = "discarded by squash";
    endcase
    if (fate_exp[idx] != FATE_ANY && fate_exp[idx] != fate) begin
      report_failure($sformatf("test %0d was %s, which the table does not expect", idx, outcome));
    end
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("test %0d %s: failed", idx, outcome);
    end else begin
      $display("test %0d %s: ok", idx, outcome);
    end
  endtask

  //----------------------------------------------------------------------
  // Reference model
  //----------------------------------------------------------------------

  task automatic check_commit(input int idx);
    isa_pkg::opcode_e    op;
    core_pkg::reg_addr_t rd;
    core_pkg::reg_addr_t rs;
    core_pkg::data_t     src;
    core_pkg::data_t     imm_ext;
    core_pkg::data_t     value;
    logic                wen;
    logic                taken;
    int                  err_before;
    int                  drop_idx;
    err_before = errors;
    op  = isa_pkg::opcode_e'(prog[idx][isa_pkg::OP_MSB:isa_pkg::OP_LSB]);
    rd  = prog[idx][isa_pkg::RD_MSB:isa_pkg::RD_LSB];
    rs  = prog[idx][isa_pkg::RS_MSB:isa_pkg::RS_LSB];
    imm_ext = {{6{prog[idx][isa_pkg::IMM_MSB]}}, prog[idx][isa_pkg::IMM_MSB:isa_pkg::IMM_LSB]};
    // All older entries have retired so the model file is current
    src   = model_regs[rs];
    value = '0;
    wen   = 1'b0;
    taken = 1'b0;
    case (op)
      isa_pkg::OP_ADDI: begin
        value = src + imm_ext;
        wen   = 1'b1;
      end
      isa_pkg::OP_XORI: begin
        value = src ^ imm_ext;
        wen   = 1'b1;
      end
      isa_pkg::OP_BEQZ: taken = (src == '0);
      default: ;
    endcase
    if (commit_seq_num != exp_seq[idx]) begin
      report_mismatch("commit_seq_num", int'(commit_seq_num), int'(exp_seq[idx]));
    end
    if (cyc - acc_cyc[idx] != LATENCY) begin
      report_mismatch("commit latency", cyc - acc_cyc[idx], LATENCY);
    end
    if (commit_wen != wen) begin
      report_mismatch("commit_wen", int'(commit_wen), int'(wen));
    end
    if (wen && commit_waddr != rd) begin
      report_mismatch("commit_waddr", int'(commit_waddr), int'(rd));
    end
    if (wen && commit_wdata != value) begin
      report_mismatch("commit_wdata", int'(commit_wdata), int'(value));
    end
    if (squash_val != taken) begin
      report_mismatch("squash_val", int'(squash_val), int'(taken));
    end
    if (taken && squash_seq_num != exp_seq[idx]) begin
      report_mismatch("squash_seq_num", int'(squash_seq_num), int'(exp_seq[idx]));
    end
    if (wen) begin
      model_regs[rd] = value;
    end
    close_test(idx, taken ? FATE_SQUASH : FATE_COMMIT, err_before);
    if (taken) begin
      // Flush younger entries and restart numbering right behind the branch
      while (inflight.size() != 0) begin
        drop_idx = inflight.pop_front();
        close_test(drop_idx, FATE_DROP, errors);
      end
      next_seq = core_pkg::seq_num_t'(exp_seq[idx] + 1'b1);
    end
  endtask

  // Runs at the falling edge where all outputs are settled
  task automatic observe_cycle();
    int idx;
    if (squash_val && !commit_val) begin
      report_failure("squash raised without a commit");
    end
    if (squash_val && instr_rdy) begin
      report_failure("instr_rdy stayed high during a squash");
    end
    if (commit_val) begin
      if (inflight.size() == 0) begin
        report_failure("commit seen with no instruction in flight");
      end else begin
        idx = inflight.pop_front();
        check_commit(idx);
      end
    end
    // Taken at the coming rising edge
    if (instr_val && instr_rdy && cur < N_TESTS) begin
      exp_seq[cur] = next_seq;
      acc_cyc[cur] = cyc;
      inflight.push_back(cur);
      next_seq = core_pkg::seq_num_t'(next_seq + 1'b1);
      cur++;
      if (cur < N_TESTS) begin
        gap_left = gap_cyc[cur];
      end
    end
  endtask

  task automatic plan_drive();
    drive_val = 1'b0;
    if (cur < N_TESTS) begin
      if (gap_left > 0) begin
        gap_left--;
      end else begin
        drive_val   = 1'b1;
        drive_instr = prog[cur];
      end
    end
  endtask

  task automatic check_reset();
    int err_before;
    err_before = errors;
    if (instr_rdy !== 1'b1) begin
      report_failure("instr_rdy is not high after reset");
    end
    if (commit_val !== 1'b0 || squash_val !== 1'b0) begin
      report_failure("commit or squash pulse right after reset");
    end
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("test reset: failed");
    end else begin
      $display("test reset: ok");
    end
  endtask

  //----------------------------------------------------------------------
  // Main sequence and watchdog
  //----------------------------------------------------------------------

  initial begin
    next_seq = '0;
    for (int r = 0; r < core_pkg::NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    load_table();
    gap_left = gap_cyc[0];
    repeat (RESET_CYCLES) @(negedge clk);
    drive_rst = 1'b0;
    @(negedge clk);
    check_reset();
    while (cur < N_TESTS || inflight.size() != 0) begin
      plan_drive();
      @(negedge clk);
      cyc++;
      observe_cycle();
    end
    // Idle tail where nothing more may retire
    repeat (LATENCY) begin
      plan_drive();
      @(negedge clk);
      cyc++;
      observe_cycle();
    end
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    repeat (RESET_CYCLES + N_TESTS * 10) @(posedge clk);
    $display("Timeout: the table did not finish within %0d cycles", N_TESTS * 10);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
logic/core_pkg.sv
logic/isa_pkg.sv
logic/core_if.sv
logic/seq_num_gen.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/result_unit.sv
logic/seq_core.sv
tb/tb_seq_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_seq_core -f src.f -o sim_seq_core
./obj_dir/sim_seq_core | tee sim.log

if grep -q "Errors found" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
